//--- hdl/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_ID_W 4
`define SOC_STRB_W (`SOC_DATA_W / 8)

// configuration register block
`define CFG_REG_NUM 8
`define LED_W 16

// address map
`define CFG_PAGE 16'h1d12
`define MEM_TOP_BITS 5

`endif

//--- hdl/axi_pkg.sv
`include "soc_macros.svh"

package axi_pkg;

    typedef logic [`SOC_ADDR_W-1:0] addr_t;
    typedef logic [`SOC_DATA_W-1:0] data_t;
    typedef logic [`SOC_ID_W-1:0]   id_t;
    typedef logic [`SOC_STRB_W-1:0] strb_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } resp_e;

    // single-beat channel payloads
    typedef struct packed {
        id_t   id;
        addr_t addr;
    } aw_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    typedef struct packed {
        id_t   id;
        resp_e resp;
    } b_chan_t;

    typedef struct packed {
        id_t   id;
        addr_t addr;
    } ar_chan_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_e resp;
    } r_chan_t;

endpackage

//--- hdl/soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

    // values double as index into the demux target vectors
    typedef enum logic [1:0] {
        TGT_ERR = 2'd0,
        TGT_MEM = 2'd1,
        TGT_CFG = 2'd2
    } target_e;

    // register index from addr[4:2]
    typedef logic [$clog2(`CFG_REG_NUM)-1:0] reg_idx_t;

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_RESP = 2'd1
    } slv_state_e;

    typedef logic [`LED_W-1:0] led_t;

endpackage

//--- hdl/addr_demux.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module addr_demux (
    input  logic              soc_clk,
    input  logic              rst_n_i,
    // master side
    input  axi_pkg::aw_chan_t slv_aw_i,
    input  logic              slv_aw_valid_i,
    output logic              slv_aw_ready_o,
    input  axi_pkg::w_chan_t  slv_w_i,
    input  logic              slv_w_valid_i,
    output logic              slv_w_ready_o,
    output axi_pkg::b_chan_t  slv_b_o,
    output logic              slv_b_valid_o,
    input  logic              slv_b_ready_i,
    input  axi_pkg::ar_chan_t slv_ar_i,
    input  logic              slv_ar_valid_i,
    output logic              slv_ar_ready_o,
    output axi_pkg::r_chan_t  slv_r_o,
    output logic              slv_r_valid_o,
    input  logic              slv_r_ready_i,
    // main memory
    output axi_pkg::aw_chan_t mem_aw_o,
    output logic              mem_aw_valid_o,
    input  logic              mem_aw_ready_i,
    output axi_pkg::w_chan_t  mem_w_o,
    output logic              mem_w_valid_o,
    input  logic              mem_w_ready_i,
    input  axi_pkg::b_chan_t  mem_b_i,
    input  logic              mem_b_valid_i,
    output logic              mem_b_ready_o,
    output axi_pkg::ar_chan_t mem_ar_o,
    output logic              mem_ar_valid_o,
    input  logic              mem_ar_ready_i,
    input  axi_pkg::r_chan_t  mem_r_i,
    input  logic              mem_r_valid_i,
    output logic              mem_r_ready_o,
    // configuration registers
    output axi_pkg::aw_chan_t cfg_aw_o,
    output logic              cfg_aw_valid_o,
    input  logic              cfg_aw_ready_i,
    output axi_pkg::w_chan_t  cfg_w_o,
    output logic              cfg_w_valid_o,
    input  logic              cfg_w_ready_i,
    input  axi_pkg::b_chan_t  cfg_b_i,
    input  logic              cfg_b_valid_i,
    output logic              cfg_b_ready_o,
    output axi_pkg::ar_chan_t cfg_ar_o,
    output logic              cfg_ar_valid_o,
    input  logic              cfg_ar_ready_i,
    input  axi_pkg::r_chan_t  cfg_r_i,
    input  logic              cfg_r_valid_i,
    output logic              cfg_r_ready_o,
    // error slave
    output axi_pkg::aw_chan_t err_aw_o,
    output logic              err_aw_valid_o,
    input  logic              err_aw_ready_i,
    output axi_pkg::w_chan_t  err_w_o,
    output logic              err_w_valid_o,
    input  logic              err_w_ready_i,
    input  axi_pkg::b_chan_t  err_b_i,
    input  logic              err_b_valid_i,
    output logic              err_b_ready_o,
    output axi_pkg::ar_chan_t err_ar_o,
    output logic              err_ar_valid_o,
    input  logic              err_ar_ready_i,
    input  axi_pkg::r_chan_t  err_r_i,
    input  logic              err_r_valid_i,
    output logic              err_r_ready_o
);

    import axi_pkg::*;
    import soc_pkg::*;

    // per-target handshake bits, bit position is the target_e value
    logic [2:0] tgt_aw_valid, tgt_aw_ready, tgt_w_valid, tgt_w_ready;
    logic [2:0] tgt_b_valid, tgt_b_ready, tgt_ar_valid, tgt_ar_ready;
    logic [2:0] tgt_r_valid, tgt_r_ready, wr_oh, rd_oh;
    b_chan_t    tgt_b [3];
    r_chan_t    tgt_r [3];
    target_e    aw_sel, ar_sel, wr_tgt, rd_tgt, wr_tgt_q, rd_tgt_q;
    logic       wr_busy_q, rd_busy_q, w_open;

    function automatic target_e decode(input addr_t addr);
        if (addr[`SOC_ADDR_W-1 -: `MEM_TOP_BITS] == '0)
            return TGT_MEM;
        else if (addr[`SOC_ADDR_W-1 -: 16] == `CFG_PAGE)
            return TGT_CFG;
        return TGT_ERR;
    endfunction

    assign tgt_aw_ready = {cfg_aw_ready_i, mem_aw_ready_i, err_aw_ready_i};
    assign tgt_w_ready  = {cfg_w_ready_i, mem_w_ready_i, err_w_ready_i};
    assign tgt_b_valid  = {cfg_b_valid_i, mem_b_valid_i, err_b_valid_i};
    assign tgt_ar_ready = {cfg_ar_ready_i, mem_ar_ready_i, err_ar_ready_i};
    assign tgt_r_valid  = {cfg_r_valid_i, mem_r_valid_i, err_r_valid_i};
    assign tgt_b = '{err_b_i, mem_b_i, cfg_b_i};
    assign tgt_r = '{err_r_i, mem_r_i, cfg_r_i};

    assign {cfg_aw_valid_o, mem_aw_valid_o, err_aw_valid_o} = tgt_aw_valid;
    assign {cfg_w_valid_o, mem_w_valid_o, err_w_valid_o}    = tgt_w_valid;
    assign {cfg_b_ready_o, mem_b_ready_o, err_b_ready_o}    = tgt_b_ready;
    assign {cfg_ar_valid_o, mem_ar_valid_o, err_ar_valid_o} = tgt_ar_valid;
    assign {cfg_r_ready_o, mem_r_ready_o, err_r_ready_o}    = tgt_r_ready;

    // request payloads fan out, only the valids are steered
    assign mem_aw_o = slv_aw_i;
    assign cfg_aw_o = slv_aw_i;
    assign err_aw_o = slv_aw_i;
    assign mem_w_o  = slv_w_i;
    assign cfg_w_o  = slv_w_i;
    assign err_w_o  = slv_w_i;
    assign mem_ar_o = slv_ar_i;
    assign cfg_ar_o = slv_ar_i;
    assign err_ar_o = slv_ar_i;

    // write path: decoded target while idle, latched one while busy
    assign aw_sel = decode(slv_aw_i.addr);
    assign wr_tgt = wr_busy_q ? wr_tgt_q : aw_sel;
    assign wr_oh  = 3'b001 << wr_tgt;
    // W may travel together with its AW, slaves take both in one cycle
    assign w_open = wr_busy_q | slv_aw_valid_i;

    assign tgt_aw_valid   = {3{slv_aw_valid_i & ~wr_busy_q}} & wr_oh;
    assign tgt_w_valid    = {3{slv_w_valid_i & w_open}} & wr_oh;
    assign tgt_b_ready    = {3{slv_b_ready_i & wr_busy_q}} & wr_oh;
    assign slv_aw_ready_o = ~wr_busy_q & tgt_aw_ready[wr_tgt];
    assign slv_w_ready_o  = w_open & tgt_w_ready[wr_tgt];
    assign slv_b_valid_o  = wr_busy_q & tgt_b_valid[wr_tgt];
    assign slv_b_o        = tgt_b[wr_tgt];

    always_ff @(posedge soc_clk) begin
        if (!rst_n_i) begin
            wr_busy_q <= 1'b0;
            wr_tgt_q  <= TGT_ERR;
        end else if (slv_aw_valid_i && slv_aw_ready_o) begin
            wr_busy_q <= 1'b1;
            wr_tgt_q  <= aw_sel;
        end else if (slv_b_valid_o && slv_b_ready_i) begin
            wr_busy_q <= 1'b0;
        end
    end

    // read path
    assign ar_sel = decode(slv_ar_i.addr);
    assign rd_tgt = rd_busy_q ? rd_tgt_q : ar_sel;
    assign rd_oh  = 3'b001 << rd_tgt;

    assign tgt_ar_valid   = {3{slv_ar_valid_i & ~rd_busy_q}} & rd_oh;
    assign tgt_r_ready    = {3{slv_r_ready_i & rd_busy_q}} & rd_oh;
    assign slv_ar_ready_o = ~rd_busy_q & tgt_ar_ready[rd_tgt];
    assign slv_r_valid_o  = rd_busy_q & tgt_r_valid[rd_tgt];
    assign slv_r_o        = tgt_r[rd_tgt];

    always_ff @(posedge soc_clk) begin
        if (!rst_n_i) begin
            rd_busy_q <= 1'b0;
            rd_tgt_q  <= TGT_ERR;
        end else if (slv_ar_valid_i && slv_ar_ready_o) begin
            rd_busy_q <= 1'b1;
            rd_tgt_q  <= ar_sel;
        end else if (slv_r_valid_o && slv_r_ready_i) begin
            rd_busy_q <= 1'b0;
        end
    end

endmodule

//--- hdl/confreg.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module confreg (
    input  logic              soc_clk,
    input  logic              rst_n_i,
    input  axi_pkg::aw_chan_t s_aw_i,
    input  logic              s_aw_valid_i,
    output logic              s_aw_ready_o,
    input  axi_pkg::w_chan_t  s_w_i,
    input  logic              s_w_valid_i,
    output logic              s_w_ready_o,
    output axi_pkg::b_chan_t  s_b_o,
    output logic              s_b_valid_o,
    input  logic              s_b_ready_i,
    input  axi_pkg::ar_chan_t s_ar_i,
    input  logic              s_ar_valid_i,
    output logic              s_ar_ready_o,
    output axi_pkg::r_chan_t  s_r_o,
    output logic              s_r_valid_o,
    input  logic              s_r_ready_i,
    output soc_pkg::led_t     led_o
);

    import axi_pkg::*;
    import soc_pkg::*;

    data_t      regs [`CFG_REG_NUM];
    slv_state_e wr_state, rd_state;
    reg_idx_t   wr_idx, rd_idx;
    b_chan_t    b_q;
    r_chan_t    r_q;
    logic       wr_fire, rd_fire;

    // AW and W are taken in the same cycle
    assign wr_fire = (wr_state == S_IDLE) & s_aw_valid_i & s_w_valid_i;
    assign rd_fire = (rd_state == S_IDLE) & s_ar_valid_i;
    assign wr_idx  = s_aw_i.addr[4:2];
    assign rd_idx  = s_ar_i.addr[4:2];

    assign s_aw_ready_o = wr_fire;
    assign s_w_ready_o  = wr_fire;
    assign s_ar_ready_o = (rd_state == S_IDLE);
    assign s_b_valid_o  = (wr_state == S_RESP);
    assign s_r_valid_o  = (rd_state == S_RESP);
    assign s_b_o        = b_q;
    assign s_r_o        = r_q;

    assign led_o = regs[0][`LED_W-1:0];

    always_ff @(posedge soc_clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CFG_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire) begin
            // byte-wise update under the strobes
            for (int b = 0; b < `SOC_STRB_W; b++) begin
                if (s_w_i.strb[b])
                    regs[wr_idx][8*b +: 8] <= s_w_i.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge soc_clk) begin
        if (!rst_n_i) begin
            wr_state <= S_IDLE;
            rd_state <= S_IDLE;
        end else begin
            if (wr_fire)
                wr_state <= S_RESP;
            else if (wr_state == S_RESP && s_b_ready_i)
                wr_state <= S_IDLE;
            if (rd_fire)
                rd_state <= S_RESP;
            else if (rd_state == S_RESP && s_r_ready_i)
                rd_state <= S_IDLE;
        end
    end

    // held responses, read sees the value before a same-cycle write
    always_ff @(posedge soc_clk) begin
        if (wr_fire)
            b_q <= '{id: s_aw_i.id, resp: OKAY};
        if (rd_fire)
            r_q <= '{id: s_ar_i.id, data: regs[rd_idx], resp: OKAY};
    end

endmodule

//--- hdl/error_slave.sv
`timescale 1ns/1ps

module error_slave (
    input  logic              soc_clk,
    input  logic              rst_n_i,
    input  axi_pkg::aw_chan_t s_aw_i,
    input  logic              s_aw_valid_i,
    output logic              s_aw_ready_o,
    input  axi_pkg::w_chan_t  s_w_i,
    input  logic              s_w_valid_i,
    output logic              s_w_ready_o,
    output axi_pkg::b_chan_t  s_b_o,
    output logic              s_b_valid_o,
    input  logic              s_b_ready_i,
    input  axi_pkg::ar_chan_t s_ar_i,
    input  logic              s_ar_valid_i,
    output logic              s_ar_ready_o,
    output axi_pkg::r_chan_t  s_r_o,
    output logic              s_r_valid_o,
    input  logic              s_r_ready_i
);

    import axi_pkg::*;
    import soc_pkg::*;

    slv_state_e wr_state, rd_state;
    id_t        b_id_q, r_id_q;
    logic       wr_fire, rd_fire;

    // write data is swallowed, only the ID is kept
    assign wr_fire = (wr_state == S_IDLE) & s_aw_valid_i & s_w_valid_i;
    assign rd_fire = (rd_state == S_IDLE) & s_ar_valid_i;

    assign s_aw_ready_o = wr_fire;
    assign s_w_ready_o  = wr_fire;
    assign s_ar_ready_o = (rd_state == S_IDLE);
    assign s_b_valid_o  = (wr_state == S_RESP);
    assign s_r_valid_o  = (rd_state == S_RESP);
    assign s_b_o        = '{id: b_id_q, resp: DECERR};
    assign s_r_o        = '{id: r_id_q, data: '0, resp: DECERR};

    always_ff @(posedge soc_clk) begin
        if (!rst_n_i) begin
            wr_state <= S_IDLE;
            rd_state <= S_IDLE;
        end else begin
            if (wr_fire)
                wr_state <= S_RESP;
            else if (wr_state == S_RESP && s_b_ready_i)
                wr_state <= S_IDLE;
            if (rd_fire)
                rd_state <= S_RESP;
            else if (rd_state == S_RESP && s_r_ready_i)
                rd_state <= S_IDLE;
        end
    end

    always_ff @(posedge soc_clk) begin
        if (wr_fire)
            b_id_q <= s_aw_i.id;
        if (rd_fire)
            r_id_q <= s_ar_i.id;
    end

endmodule

//--- hdl/soc_top.sv
`timescale 1ns/1ps

module soc_top (
    input  logic              soc_clk,
    input  logic              rst_n_i,
    // cpu master port
    input  axi_pkg::aw_chan_t cpu_aw_i,
    input  logic              cpu_aw_valid_i,
    output logic              cpu_aw_ready_o,
    input  axi_pkg::w_chan_t  cpu_w_i,
    input  logic              cpu_w_valid_i,
    output logic              cpu_w_ready_o,
    output axi_pkg::b_chan_t  cpu_b_o,
    output logic              cpu_b_valid_o,
    input  logic              cpu_b_ready_i,
    input  axi_pkg::ar_chan_t cpu_ar_i,
    input  logic              cpu_ar_valid_i,
    output logic              cpu_ar_ready_o,
    output axi_pkg::r_chan_t  cpu_r_o,
    output logic              cpu_r_valid_o,
    input  logic              cpu_r_ready_i,
    // external memory
    output axi_pkg::aw_chan_t mem_aw_o,
    output logic              mem_aw_valid_o,
    input  logic              mem_aw_ready_i,
    output axi_pkg::w_chan_t  mem_w_o,
    output logic              mem_w_valid_o,
    input  logic              mem_w_ready_i,
    input  axi_pkg::b_chan_t  mem_b_i,
    input  logic              mem_b_valid_i,
    output logic              mem_b_ready_o,
    output axi_pkg::ar_chan_t mem_ar_o,
    output logic              mem_ar_valid_o,
    input  logic              mem_ar_ready_i,
    input  axi_pkg::r_chan_t  mem_r_i,
    input  logic              mem_r_valid_i,
    output logic              mem_r_ready_o,
    output soc_pkg::led_t     led_o
);

    import axi_pkg::*;

    aw_chan_t cfg_aw, err_aw;
    w_chan_t  cfg_w, err_w;
    b_chan_t  cfg_b, err_b;
    ar_chan_t cfg_ar, err_ar;
    r_chan_t  cfg_r, err_r;
    logic     cfg_aw_valid, cfg_aw_ready, cfg_w_valid, cfg_w_ready, cfg_b_valid, cfg_b_ready;
    logic     cfg_ar_valid, cfg_ar_ready, cfg_r_valid, cfg_r_ready;
    logic     err_aw_valid, err_aw_ready, err_w_valid, err_w_ready, err_b_valid, err_b_ready;
    logic     err_ar_valid, err_ar_ready, err_r_valid, err_r_ready;

    addr_demux u_addr_demux (
        .soc_clk (soc_clk),
        .rst_n_i (rst_n_i),
        .slv_aw_i(cpu_aw_i), .slv_aw_valid_i(cpu_aw_valid_i), .slv_aw_ready_o(cpu_aw_ready_o),
        .slv_w_i (cpu_w_i),  .slv_w_valid_i (cpu_w_valid_i),  .slv_w_ready_o (cpu_w_ready_o),
        .slv_b_o (cpu_b_o),  .slv_b_valid_o (cpu_b_valid_o),  .slv_b_ready_i (cpu_b_ready_i),
        .slv_ar_i(cpu_ar_i), .slv_ar_valid_i(cpu_ar_valid_i), .slv_ar_ready_o(cpu_ar_ready_o),
        .slv_r_o (cpu_r_o),  .slv_r_valid_o (cpu_r_valid_o),  .slv_r_ready_i (cpu_r_ready_i),
        .mem_aw_o(mem_aw_o), .mem_aw_valid_o(mem_aw_valid_o), .mem_aw_ready_i(mem_aw_ready_i),
        .mem_w_o (mem_w_o),  .mem_w_valid_o (mem_w_valid_o),  .mem_w_ready_i (mem_w_ready_i),
        .mem_b_i (mem_b_i),  .mem_b_valid_i (mem_b_valid_i),  .mem_b_ready_o (mem_b_ready_o),
        .mem_ar_o(mem_ar_o), .mem_ar_valid_o(mem_ar_valid_o), .mem_ar_ready_i(mem_ar_ready_i),
        .mem_r_i (mem_r_i),  .mem_r_valid_i (mem_r_valid_i),  .mem_r_ready_o (mem_r_ready_o),
        .cfg_aw_o(cfg_aw),   .cfg_aw_valid_o(cfg_aw_valid),   .cfg_aw_ready_i(cfg_aw_ready),
        .cfg_w_o (cfg_w),    .cfg_w_valid_o (cfg_w_valid),    .cfg_w_ready_i (cfg_w_ready),
        .cfg_b_i (cfg_b),    .cfg_b_valid_i (cfg_b_valid),    .cfg_b_ready_o (cfg_b_ready),
        .cfg_ar_o(cfg_ar),   .cfg_ar_valid_o(cfg_ar_valid),   .cfg_ar_ready_i(cfg_ar_ready),
        .cfg_r_i (cfg_r),    .cfg_r_valid_i (cfg_r_valid),    .cfg_r_ready_o (cfg_r_ready),
        .err_aw_o(err_aw),   .err_aw_valid_o(err_aw_valid),   .err_aw_ready_i(err_aw_ready),
        .err_w_o (err_w),    .err_w_valid_o (err_w_valid),    .err_w_ready_i (err_w_ready),
        .err_b_i (err_b),    .err_b_valid_i (err_b_valid),    .err_b_ready_o (err_b_ready),
        .err_ar_o(err_ar),   .err_ar_valid_o(err_ar_valid),   .err_ar_ready_i(err_ar_ready),
        .err_r_i (err_r),    .err_r_valid_i (err_r_valid),    .err_r_ready_o (err_r_ready)
    );

    // 0x1d12_xxxx page
    confreg u_confreg (
        .soc_clk(soc_clk),
        .rst_n_i(rst_n_i),
        .s_aw_i (cfg_aw), .s_aw_valid_i(cfg_aw_valid), .s_aw_ready_o(cfg_aw_ready),
        .s_w_i  (cfg_w),  .s_w_valid_i (cfg_w_valid),  .s_w_ready_o (cfg_w_ready),
        .s_b_o  (cfg_b),  .s_b_valid_o (cfg_b_valid),  .s_b_ready_i (cfg_b_ready),
        .s_ar_i (cfg_ar), .s_ar_valid_i(cfg_ar_valid), .s_ar_ready_o(cfg_ar_ready),
        .s_r_o  (cfg_r),  .s_r_valid_o (cfg_r_valid),  .s_r_ready_i (cfg_r_ready),
        .led_o  (led_o)
    );

    // everything outside memory and the confreg page
    error_slave u_error_slave (
        .soc_clk(soc_clk),
        .rst_n_i(rst_n_i),
        .s_aw_i (err_aw), .s_aw_valid_i(err_aw_valid), .s_aw_ready_o(err_aw_ready),
        .s_w_i  (err_w),  .s_w_valid_i (err_w_valid),  .s_w_ready_o (err_w_ready),
        .s_b_o  (err_b),  .s_b_valid_o (err_b_valid),  .s_b_ready_i (err_b_ready),
        .s_ar_i (err_ar), .s_ar_valid_i(err_ar_valid), .s_ar_ready_o(err_ar_ready),
        .s_r_o  (err_r),  .s_r_valid_o (err_r_valid),  .s_r_ready_i (err_r_ready)
    );

endmodule

//--- verification/tb_soc_checks.svh
`ifndef TB_SOC_CHECKS_SVH
`define TB_SOC_CHECKS_SVH

// reference copies of the register block and of main memory
data_t model_regs [`CFG_REG_NUM] = '{default: '0};
data_t model_mem [addr_t];

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
endtask

task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    abort_run($sformatf("error: %s expected 0x%0h, got 0x%0h", name, exp, act));
endtask

// memory below the top-bits boundary, confreg on its page, error slave elsewhere
function automatic target_e model_target(input addr_t addr);
    if (addr < (32'd1 << (`SOC_ADDR_W - `MEM_TOP_BITS)))
        return TGT_MEM;
    if (addr[31:16] == `CFG_PAGE)
        return TGT_CFG;
    return TGT_ERR;
endfunction

function automatic data_t merge_bytes(input data_t old, input data_t data, input strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < `SOC_STRB_W; b++) begin
        if (strb[b])
            res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
endfunction

// unwritten memory reads as zero
function automatic data_t model_word(input addr_t addr);
    return model_mem.exists(addr) ? model_mem[addr] : '0;
endfunction

function automatic resp_e model_write(input addr_t addr, input data_t data, input strb_t strb);
    if (model_target(addr) == TGT_ERR)
        return DECERR;
    if (model_target(addr) == TGT_CFG)
        model_regs[addr[4:2]] = merge_bytes(model_regs[addr[4:2]], data, strb);
    else
        model_mem[addr] = merge_bytes(model_word(addr), data, strb);
    return OKAY;
endfunction

function automatic r_chan_t expected_read(input id_t id, input addr_t addr);
    r_chan_t r;
    r.id   = id;
    r.data = '0;
    r.resp = OKAY;
    case (model_target(addr))
        TGT_CFG: r.data = model_regs[addr[4:2]];
        TGT_MEM: r.data = model_word(addr);
        default: r.resp = DECERR;
    endcase
    return r;
endfunction

task automatic check_b(input b_chan_t exp, input b_chan_t act);
    if (act !== exp)
        report_mismatch("cpu_b_o", 64'(exp), 64'(act));
endtask

task automatic check_r(input r_chan_t exp, input r_chan_t act);
    if (act !== exp)
        report_mismatch("cpu_r_o", 64'(exp), 64'(act));
endtask

task automatic check_led(input led_t exp, input led_t act);
    if (act !== exp)
        report_mismatch("led_o", 64'(exp), 64'(act));
endtask

task automatic check_aw(input aw_chan_t exp, input aw_chan_t act);
    if (act !== exp)
        report_mismatch("mem_aw_o", 64'(exp), 64'(act));
endtask

task automatic check_w(input w_chan_t exp, input w_chan_t act);
    if (act !== exp)
        report_mismatch("mem_w_o", 64'(exp), 64'(act));
endtask

task automatic check_ar(input ar_chan_t exp, input ar_chan_t act);
    if (act !== exp)
        report_mismatch("mem_ar_o", 64'(exp), 64'(act));
endtask

`endif

//--- verification/tb_soc_top.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc_top;

    import axi_pkg::*;
    import soc_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_CFG_WR     = 40;
    localparam int N_CFG_RD     = 24;
    localparam int N_ERR        = 16;
    localparam int N_MEM        = 32;
    localparam int N_PAIR       = 40;
    localparam int N_TXN = N_CFG_WR + N_CFG_RD + 2 * N_ERR + `CFG_REG_NUM + 2 * N_MEM + 2 * N_PAIR;
    // bound for one transaction with stalls on both sides
    localparam int TXN_CYCLES   = 64;

    logic        soc_clk, rst_n_i;
    logic        cpu_aw_valid_i, cpu_aw_ready_o, cpu_w_valid_i, cpu_w_ready_o;
    logic        cpu_b_valid_o, cpu_b_ready_i, cpu_ar_valid_i, cpu_ar_ready_o;
    logic        cpu_r_valid_o, cpu_r_ready_i;
    logic        mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
    logic        mem_b_valid_i, mem_b_ready_o, mem_ar_valid_o, mem_ar_ready_i;
    logic        mem_r_valid_i, mem_r_ready_o;
    aw_chan_t    cpu_aw_i, mem_aw_o, exp_aw;
    w_chan_t     cpu_w_i, mem_w_o, exp_w;
    b_chan_t     cpu_b_o, mem_b_i;
    ar_chan_t    cpu_ar_i, mem_ar_o, exp_ar;
    r_chan_t     cpu_r_o, mem_r_i;
    led_t        led_o;
    data_t       mem_store [addr_t];
    logic [31:0] lfsr_q = 32'hfdd2_42c3;
    target_e     tgt_list [3] = '{TGT_ERR, TGT_MEM, TGT_CFG};

    `include "tb_soc_checks.svh"

    soc_top u_soc_top (.*);

    initial begin
        soc_clk = 1'b0;
        forever #(CLK_PERIOD / 2) soc_clk = ~soc_clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    // one step for each bit returned
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic addr_t random_addr(input target_e t);
        addr_t a;
        a = rand_bits(32);
        case (t)
            // two small windows at both ends of memory so reads hit earlier writes
            TGT_MEM: a = {5'd0, {19{a[6]}}, a[5:0], 2'b00};
            TGT_CFG: a = {`CFG_PAGE, a[13:0], 2'b00};
            default: if (model_target(a) != TGT_ERR) a[30] = 1'b1;
        endcase
        return a;
    endfunction

    // starts and ends 2 ns after a rising edge
    task automatic write_txn(input addr_t addr, input data_t data, input strb_t strb);
        id_t     id;
        b_chan_t got_b, exp_b;
        logic    aw_hs, w_hs, b_done;
        id             = id_t'(rand_bits(`SOC_ID_W));
        exp_aw         = '{id: id, addr: addr};
        exp_w          = '{data: data, strb: strb};
        cpu_aw_i       = exp_aw;
        cpu_w_i        = exp_w;
        cpu_aw_valid_i = 1'b1;
        cpu_w_valid_i  = 1'b1;
        b_done         = 1'b0;
        while (!b_done) begin
            cpu_b_ready_i = rand_bits(2) != 0;
            @(negedge soc_clk);
            aw_hs  = cpu_aw_valid_i && cpu_aw_ready_o;
            w_hs   = cpu_w_valid_i && cpu_w_ready_o;
            b_done = cpu_b_valid_o && cpu_b_ready_i;
            got_b  = cpu_b_o;
            @(posedge soc_clk);
            #2;
            if (aw_hs)
                cpu_aw_valid_i = 1'b0;
            if (w_hs)
                cpu_w_valid_i = 1'b0;
        end
        cpu_b_ready_i = 1'b0;
        if (cpu_aw_valid_i || cpu_w_valid_i)
            abort_run("write response came back before the request was accepted");
        exp_b = '{id: id, resp: model_write(addr, data, strb)};
        check_b(exp_b, got_b);
        check_led(model_regs[0][`LED_W-1:0], led_o);
    endtask

    task automatic read_txn(input addr_t addr);
        id_t     id;
        r_chan_t got_r;
        logic    ar_hs, r_done;
        id             = id_t'(rand_bits(`SOC_ID_W));
        exp_ar         = '{id: id, addr: addr};
        cpu_ar_i       = exp_ar;
        cpu_ar_valid_i = 1'b1;
        r_done         = 1'b0;
        while (!r_done) begin
            cpu_r_ready_i = rand_bits(2) != 0;
            @(negedge soc_clk);
            ar_hs  = cpu_ar_valid_i && cpu_ar_ready_o;
            r_done = cpu_r_valid_o && cpu_r_ready_i;
            got_r  = cpu_r_o;
            @(posedge soc_clk);
            #2;
            if (ar_hs)
                cpu_ar_valid_i = 1'b0;
        end
        cpu_r_ready_i = 1'b0;
        if (cpu_ar_valid_i)
            abort_run("read response came back before the address was accepted");
        check_r(expected_read(id, addr), got_r);
    endtask

    // memory write side takes AW and W in turn and answers B after a random delay
    initial begin : mem_write_side
        aw_chan_t aw;
        w_chan_t  w;
        logic     hs;
        @(posedge rst_n_i);
        forever begin
            hs = 1'b0;
            while (!hs) begin
                @(posedge soc_clk);
                #2;
                mem_aw_ready_i = rand_bits(2) != 0;
                @(negedge soc_clk);
                hs = mem_aw_valid_o && mem_aw_ready_i;
            end
            aw = mem_aw_o;
            check_aw(exp_aw, aw);
            hs = 1'b0;
            while (!hs) begin
                @(posedge soc_clk);
                #2;
                mem_aw_ready_i = 1'b0;
                mem_w_ready_i  = rand_bits(2) != 0;
                @(negedge soc_clk);
                hs = mem_w_valid_o && mem_w_ready_i;
            end
            w = mem_w_o;
            check_w(exp_w, w);
            mem_store[aw.addr] = merge_bytes(mem_store.exists(aw.addr) ? mem_store[aw.addr] : '0,
                                             w.data, w.strb);
            @(posedge soc_clk);
            #2;
            mem_w_ready_i = 1'b0;
            repeat (rand_bits(2)) begin
                @(posedge soc_clk);
                #2;
            end
            mem_b_i       = '{id: aw.id, resp: OKAY};
            mem_b_valid_i = 1'b1;
            @(negedge soc_clk);
            while (!mem_b_ready_o) @(negedge soc_clk);
            @(posedge soc_clk);
            #2;
            mem_b_valid_i = 1'b0;
        end
    end

    initial begin : mem_read_side
        ar_chan_t ar;
        logic     hs;
        @(posedge rst_n_i);
        forever begin
            hs = 1'b0;
            while (!hs) begin
                @(posedge soc_clk);
                #2;
                mem_ar_ready_i = rand_bits(2) != 0;
                @(negedge soc_clk);
                hs = mem_ar_valid_o && mem_ar_ready_i;
            end
            ar = mem_ar_o;
            check_ar(exp_ar, ar);
            @(posedge soc_clk);
            #2;
            mem_ar_ready_i = 1'b0;
            repeat (rand_bits(2)) begin
                @(posedge soc_clk);
                #2;
            end
            mem_r_i.id    = ar.id;
            mem_r_i.data  = mem_store.exists(ar.addr) ? mem_store[ar.addr] : '0;
            mem_r_i.resp  = OKAY;
            mem_r_valid_i = 1'b1;
            @(negedge soc_clk);
            while (!mem_r_ready_o) @(negedge soc_clk);
            @(posedge soc_clk);
            #2;
            mem_r_valid_i = 1'b0;
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + N_TXN * TXN_CYCLES));
        abort_run("timeout: the transactions did not finish in time");
    end

    initial begin : stimulus
        int wi;
        int ri;
        {cpu_aw_valid_i, cpu_w_valid_i, cpu_b_ready_i, cpu_ar_valid_i, cpu_r_ready_i} = '0;
        {mem_aw_ready_i, mem_w_ready_i, mem_b_valid_i, mem_ar_ready_i, mem_r_valid_i} = '0;
        cpu_aw_i = '0;
        cpu_w_i  = '0;
        cpu_ar_i = '0;
        mem_b_i  = '0;
        mem_r_i  = '0;
        rst_n_i  = 1'b0;
        repeat (RESET_CYCLES) @(posedge soc_clk);
        #2;
        rst_n_i = 1'b1;
        @(negedge soc_clk);
        if ({cpu_b_valid_o, cpu_r_valid_o, mem_aw_valid_o, mem_w_valid_o, mem_ar_valid_o} !== 5'b0)
            abort_run("a response or memory valid is not low right after reset");
        check_led('0, led_o);
        @(posedge soc_clk);
        #2;
        // strobed confreg writes followed by reads
        repeat (N_CFG_WR) write_txn(random_addr(TGT_CFG), rand_bits(32), strb_t'(rand_bits(4)));
        repeat (N_CFG_RD) read_txn(random_addr(TGT_CFG));
        // unmapped space leaves the registers as they were
        repeat (N_ERR) write_txn(random_addr(TGT_ERR), rand_bits(32), strb_t'(rand_bits(4)));
        repeat (N_ERR) read_txn(random_addr(TGT_ERR));
        for (int i = 0; i < `CFG_REG_NUM; i++)
            read_txn({`CFG_PAGE, 11'd0, 3'(i), 2'b00});
        repeat (N_MEM) write_txn(random_addr(TGT_MEM), rand_bits(32), strb_t'(rand_bits(4)));
        repeat (N_MEM) read_txn(random_addr(TGT_MEM));
        // a write and a read in flight to different targets
        repeat (N_PAIR) begin
            wi = rand_bits(2) % 3;
            ri = (wi + 1 + rand_bits(1)) % 3;
            fork
                write_txn(random_addr(tgt_list[wi]), rand_bits(32), strb_t'(rand_bits(4)));
                read_txn(random_addr(tgt_list[ri]));
            join
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+hdl
+incdir+verification
hdl/axi_pkg.sv
hdl/soc_pkg.sv
hdl/addr_demux.sv
hdl/confreg.sv
hdl/error_slave.sv
hdl/soc_top.sv
verification/tb_soc_top.sv
